// ==== sim.f ====
verilog/cache_pkg.sv
verilog/tag_store.sv
verilog/line_state.sv
verilog/data_store.sv
verilog/cache_ctrl.sv
verilog/store_buffer.sv
verilog/mem_arbiter.sv
verilog/main_memory.sv
verilog/cache_top.sv
verif/cache_checker.sv
verif/tb_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_cache -f sim.f -o tb_cache
./obj_dir/tb_cache | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation reported no failure"

// ==== verif/tb_cache.sv ====
`timescale 1ns/100ps

module tb_cache;
    import cache_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    localparam int pool_size    = 24;
    localparam int n_tests      = 6;
    localparam int n_first      = 8;
    localparam int n_reread     = 8;
    localparam int n_overwrite  = 8;
    localparam int n_rr_tags    = 5;
    localparam int n_burst      = 8;
    localparam int n_random     = 200;
    localparam int n_requests   = n_first + n_reread + 3 * n_overwrite
                                  + 2 * n_rr_tags + n_burst + n_random;
    // worst case per request, plus reset and the gaps between tests
    localparam int req_bound       = 2 * mem_latency * sb_depth + 6;
    localparam int watchdog_cycles = n_requests * req_bound + reset_cycles
                                     + 4 * n_tests + 10;
    localparam logic [index_w-1:0] rr_set = index_w'(2);

    logic                clk;
    logic                reset;
    logic                req_valid;
    logic                req_write;
    logic [addr_w-1:0]   req_addr;
    logic [data_w-1:0]   req_wdata;
    logic                resp_valid;
    logic [data_w-1:0]   resp_rdata;
    logic                busy;
    logic                test_end;
    int                  test_id;
    logic                need_backpressure;
    logic                summary;
    int                  error_count;

    logic [addr_w-1:0]   pool [pool_size];
    integer              seed;
    logic [tag_w-1:0]    rr_base;
    logic [31:0]         rnd;
    int                  pick;

    cache_top cache_top_inst (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata), .busy(busy)
    );

    cache_checker cache_checker_inst (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata), .busy(busy),
        .test_end(test_end), .test_id(test_id),
        .need_backpressure(need_backpressure), .summary(summary),
        .error_count(error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
        $display("TB FAILED");
        $finish;
    end

    // six tags per set, so the random test evicts
    task build_pool();
        logic [tag_w-1:0] base;
        base = tag_w'($random(seed));
        for (int i = 0; i < pool_size; i++) begin
            pool[i] = {base + tag_w'(37 * (i / num_sets)), index_w'(i % num_sets)};
        end
    endtask

    task issue_request(input logic wr, input logic [addr_w-1:0] a,
                       input logic [data_w-1:0] d);
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= a;
        req_wdata <= d;
        @(posedge clk);
        req_valid <= 1'b0;
        req_write <= 1'b0;
        // response first, then a quiet cycle with busy low
        @(negedge clk);
        while (!resp_valid) begin
            @(negedge clk);
        end
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task close_test(input int id);
        @(posedge clk);
        test_id  <= id;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin
        seed              = 32'h5127_3fea;
        reset             = 1'b1;
        req_valid         = 1'b0;
        req_write         = 1'b0;
        req_addr          = '0;
        req_wdata         = '0;
        test_end          = 1'b0;
        test_id           = 0;
        need_backpressure = 1'b0;
        summary           = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        build_pool();

        // cold reads all miss and return zero
        for (int i = 0; i < n_first; i++) begin
            issue_request(1'b0, pool[i], '0);
        end
        close_test(1);

        // two lines per set, still resident
        for (int i = 0; i < n_reread; i++) begin
            issue_request(1'b0, pool[i], '0);
        end
        close_test(2);

        // half cached, half not
        for (int i = 0; i < n_overwrite; i++) begin
            rnd = $random(seed);
            issue_request(1'b1, pool[i + 4], rnd[data_w-1:0]);
            issue_request(1'b1, pool[i + 4], rnd[31:32-data_w]);
            issue_request(1'b0, pool[i + 4], '0);
        end
        close_test(3);

        // five tags into one 4-way set
        rr_base = tag_w'($random(seed));
        for (int k = 0; k < n_rr_tags; k++) begin
            issue_request(1'b0, {rr_base + tag_w'(53 * k), rr_set}, '0);
        end
        // reread newest tag first
        for (int k = n_rr_tags - 1; k >= 0; k--) begin
            issue_request(1'b0, {rr_base + tag_w'(53 * k), rr_set}, '0);
        end
        close_test(4);

        need_backpressure <= 1'b1;
        for (int i = 0; i < n_burst; i++) begin
            rnd = $random(seed);
            issue_request(1'b1, pool[(i * 3) % pool_size], rnd[data_w-1:0]);
        end
        close_test(5);
        need_backpressure <= 1'b0;

        for (int i = 0; i < n_random; i++) begin
            pick = $unsigned($random(seed)) % pool_size;
            rnd  = $random(seed);
            issue_request(rnd[31], pool[pick], rnd[data_w-1:0]);
        end
        close_test(6);

        @(posedge clk);
        summary <= 1'b1;
        @(posedge clk);
        summary <= 1'b0;
        repeat (2) @(posedge clk);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/cache_checker.sv ====
`timescale 1ns/100ps

module cache_checker (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_valid,
    input  logic                         req_write,
    input  logic [cache_pkg::addr_w-1:0] req_addr,
    input  logic [cache_pkg::data_w-1:0] req_wdata,
    input  logic                         resp_valid,
    input  logic [cache_pkg::data_w-1:0] resp_rdata,
    input  logic                         busy,
    input  logic                         test_end,
    input  int                           test_id,
    input  logic                         need_backpressure,
    input  logic                         summary,
    output int                           error_count
);
    import cache_pkg::*;

    // what the next responses should look like
    localparam int pend_none       = 0;
    localparam int pend_quick      = 1;
    localparam int pend_miss_first = 2;
    localparam int pend_miss_wait  = 3;

    logic [data_w-1:0] ref_mem [mem_words];
    logic [tag_w-1:0]  m_tag   [num_sets][num_ways];
    logic              m_valid [num_sets][num_ways];
    int                m_rr    [num_sets];

    int                pend;
    logic              pend_write;
    logic [data_w-1:0] pend_data;
    logic              full_seen;
    int                test_reqs;
    int                test_errs;
    int                total_reqs;
    int                total_resps;
    int                tests_run;
    int                tests_bad;

    task report_value(input string sig, input logic [31:0] exp_val,
                      input logic [31:0] got_val);
        $display("ERR t=%0t %s expected=%0h got=%0h", $time, sig, exp_val, got_val);
        test_errs++;
        error_count++;
    endtask

    task report_problem(input string msg);
        $display("error at %0t: %s", $time, msg);
        test_errs++;
        error_count++;
    endtask

    function automatic logic model_hit(input logic [addr_w-1:0] a);
        int   s;
        logic found;
        s = int'(a[index_w-1:0]);
        found = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[s][w] && (m_tag[s][w] == a[addr_w-1:index_w])) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // refill goes to the set's round-robin way
    task model_fill(input logic [addr_w-1:0] a);
        int s;
        s = int'(a[index_w-1:0]);
        m_tag[s][m_rr[s]]   = a[addr_w-1:index_w];
        m_valid[s][m_rr[s]] = 1'b1;
        m_rr[s] = (m_rr[s] + 1) % num_ways;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                ref_mem[i] = '0;
            end
            for (int s = 0; s < num_sets; s++) begin
                m_rr[s] = 0;
                for (int w = 0; w < num_ways; w++) begin
                    m_tag[s][w]   = '0;
                    m_valid[s][w] = 1'b0;
                end
            end
            pend        = pend_none;
            pend_write  = 1'b0;
            pend_data   = '0;
            full_seen   = 1'b0;
            test_reqs   = 0;
            test_errs   = 0;
            total_reqs  = 0;
            total_resps = 0;
            tests_run   = 0;
            tests_bad   = 0;
            error_count = 0;
        end else begin
            // busy without a refill means a full store buffer
            if (busy && (pend < pend_miss_first)) begin
                full_seen = 1'b1;
            end

            if (pend == pend_quick) begin
                if (resp_valid !== 1'b1) begin
                    report_value("resp_valid", 32'(1'b1), 32'(resp_valid));
                end else begin
                    total_resps++;
                    if (!pend_write && (resp_rdata !== pend_data)) begin
                        report_value("resp_rdata", 32'(pend_data), 32'(resp_rdata));
                    end
                end
                if (!pend_write && (busy !== 1'b0)) begin
                    report_value("busy", 32'(1'b0), 32'(busy));
                end
                pend = pend_none;
            end else if (pend == pend_miss_first) begin
                if (resp_valid !== 1'b0) begin
                    report_value("resp_valid", 32'(1'b0), 32'(resp_valid));
                end
                if (busy !== 1'b1) begin
                    report_value("busy", 32'(1'b1), 32'(busy));
                end
                pend = pend_miss_wait;
            end else if (pend == pend_miss_wait) begin
                if (resp_valid === 1'b1) begin
                    total_resps++;
                    if (resp_rdata !== pend_data) begin
                        report_value("resp_rdata", 32'(pend_data), 32'(resp_rdata));
                    end
                    pend = pend_none;
                end else if (busy !== 1'b1) begin
                    report_value("busy", 32'(1'b1), 32'(busy));
                end
            end else if (resp_valid === 1'b1) begin
                report_problem("response arrived with no request outstanding");
            end

            if (req_valid) begin
                test_reqs++;
                total_reqs++;
                if (busy) begin
                    report_problem("request was issued while busy was high");
                end
                if (pend != pend_none) begin
                    report_problem("request overlaps one still outstanding");
                end
                pend_write = req_write;
                if (req_write) begin
                    ref_mem[req_addr] = req_wdata;
                    pend = pend_quick;
                end else begin
                    pend_data = ref_mem[req_addr];
                    if (model_hit(req_addr)) begin
                        pend = pend_quick;
                    end else begin
                        model_fill(req_addr);
                        pend = pend_miss_first;
                    end
                end
            end

            if (test_end) begin
                if (pend != pend_none) begin
                    report_problem("a request was still outstanding at the end of the test");
                end
                if (need_backpressure && !full_seen) begin
                    report_problem("busy never rose while writes filled the store buffer");
                end
                tests_run++;
                if (test_errs != 0) begin
                    tests_bad++;
                end
                $display("test %0d: %0d requests, %0d errors, %s", test_id, test_reqs,
                         test_errs, (test_errs == 0) ? "pass" : "fail");
                test_reqs = 0;
                test_errs = 0;
                full_seen = 1'b0;
            end

            if (summary) begin
                if (total_reqs != total_resps) begin
                    report_problem("requests and responses do not match up, one was lost");
                end
                $display("totals: %0d tests, %0d bad, %0d requests, %0d responses, %0d errors",
                         tests_run, tests_bad, total_reqs, total_resps, error_count);
            end
        end
    end

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/100ps

module cache_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_valid,
    input  logic                         req_write,
    input  logic [cache_pkg::addr_w-1:0] req_addr,
    input  logic [cache_pkg::data_w-1:0] req_wdata,
    output logic                         resp_valid,
    output logic [cache_pkg::data_w-1:0] resp_rdata,
    output logic                         busy
);
    import cache_pkg::*;

    // lookup
    logic [index_w-1:0]  index;
    logic [tag_w-1:0]    tag_in;
    logic [num_ways-1:0] valid;
    logic [num_ways-1:0] hit;
    logic [num_ways-1:0] victim;
    logic [num_ways-1:0] way_sel;
    logic                tag_we;
    logic                fill;
    logic [num_ways-1:0] way_we;
    logic [data_w-1:0]   dwdata;
    logic [data_w-1:0]   drdata;

    // memory side
    logic                sb_full;
    logic                sb_push;
    logic                sb_req;
    logic [addr_w-1:0]   sb_addr;
    logic [data_w-1:0]   sb_data;
    logic                sb_gnt;
    logic                rf_req;
    logic [addr_w-1:0]   rf_addr;
    logic                rf_gnt;
    logic                mem_start;
    logic                mem_we;
    logic [addr_w-1:0]   mem_addr;
    logic [data_w-1:0]   mem_wdata;
    logic                mem_done;
    logic [data_w-1:0]   mem_rdata;

    cache_ctrl cache_ctrl_inst (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata), .busy(busy),
        .sb_full(sb_full), .sb_push(sb_push),
        .hit(hit), .victim(victim), .tag_we(tag_we), .way_sel(way_sel),
        .fill(fill), .way_we(way_we), .dwdata(dwdata), .drdata(drdata),
        .rf_req(rf_req), .rf_addr(rf_addr), .rf_gnt(rf_gnt),
        .mem_done(mem_done), .mem_rdata(mem_rdata),
        .index(index), .tag_in(tag_in)
    );

    tag_store tag_store_inst (
        .clk(clk), .index(index), .tag_in(tag_in), .valid(valid),
        .tag_we(tag_we), .way_sel(way_sel), .hit(hit), .tag_out()
    );

    line_state line_state_inst (
        .clk(clk), .reset(reset), .index(index), .fill(fill),
        .valid(valid), .victim(victim)
    );

    // hit vector doubles as the data read select
    data_store data_store_inst (
        .clk(clk), .index(index), .way_we(way_we), .wdata(dwdata),
        .rsel(hit), .rdata(drdata)
    );

    store_buffer store_buffer_inst (
        .clk(clk), .reset(reset), .push(sb_push),
        .push_addr(req_addr), .push_data(req_wdata), .full(sb_full),
        .sb_req(sb_req), .sb_addr(sb_addr), .sb_data(sb_data),
        .sb_gnt(sb_gnt), .mem_done(mem_done)
    );

    mem_arbiter mem_arbiter_inst (
        .clk(clk), .reset(reset), .sb_req(sb_req), .rf_req(rf_req),
        .sb_gnt(sb_gnt), .rf_gnt(rf_gnt), .mem_start(mem_start),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .sb_addr(sb_addr), .sb_data(sb_data), .rf_addr(rf_addr),
        .mem_done(mem_done)
    );

    main_memory main_memory_inst (
        .clk(clk), .reset(reset), .mem_start(mem_start), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_done(mem_done), .mem_rdata(mem_rdata)
    );

endmodule

// ==== verilog/main_memory.sv ====
`timescale 1ns/100ps

module main_memory (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         mem_start,
    input  logic                         mem_we,
    input  logic [cache_pkg::addr_w-1:0] mem_addr,
    input  logic [cache_pkg::data_w-1:0] mem_wdata,
    output logic                         mem_done,
    output logic [cache_pkg::data_w-1:0] mem_rdata
);
    import cache_pkg::*;

    localparam int cnt_w = $clog2(mem_latency + 1);

    logic [data_w-1:0] mem_array [mem_words];
    logic [cnt_w-1:0]  cnt;
    logic [addr_w-1:0] addr_q;
    logic [data_w-1:0] wdata_q;
    logic              we_q;

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem_array[i] = '0;
        end
    end

    // countdown from start, done on the last count
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (mem_start) begin
            cnt <= cnt_w'(mem_latency);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_start) begin
            addr_q  <= mem_addr;
            wdata_q <= mem_wdata;
            we_q    <= mem_we;
        end
        if (mem_done && we_q) begin
            mem_array[addr_q] <= wdata_q;
        end
    end

    assign mem_done  = (cnt == cnt_w'(1));
    assign mem_rdata = mem_array[addr_q];

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         sb_req,
    input  logic                         rf_req,
    output logic                         sb_gnt,
    output logic                         rf_gnt,
    output logic                         mem_start,
    output logic                         mem_we,
    output logic [cache_pkg::addr_w-1:0] mem_addr,
    output logic [cache_pkg::data_w-1:0] mem_wdata,
    input  logic [cache_pkg::addr_w-1:0] sb_addr,
    input  logic [cache_pkg::data_w-1:0] sb_data,
    input  logic [cache_pkg::addr_w-1:0] rf_addr,
    input  logic                         mem_done
);
    import cache_pkg::*;

    logic port_busy;

    assign port_busy = sb_gnt || rf_gnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            sb_gnt    <= 1'b0;
            rf_gnt    <= 1'b0;
            mem_start <= 1'b0;
        end else begin
            mem_start <= 1'b0;
            if (port_busy) begin
                // grant held until the access finishes
                if (mem_done) begin
                    sb_gnt <= 1'b0;
                    rf_gnt <= 1'b0;
                end
            end else if (sb_req) begin
                // queued writes go first so refills see current data
                sb_gnt    <= 1'b1;
                mem_start <= 1'b1;
            end else if (rf_req) begin
                rf_gnt    <= 1'b1;
                mem_start <= 1'b1;
            end
        end
    end

    assign mem_we    = sb_gnt;
    assign mem_addr  = sb_gnt ? sb_addr : rf_addr;
    assign mem_wdata = sb_data;

endmodule

// ==== verilog/store_buffer.sv ====
`timescale 1ns/100ps

module store_buffer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         push,
    input  logic [cache_pkg::addr_w-1:0] push_addr,
    input  logic [cache_pkg::data_w-1:0] push_data,
    output logic                         full,
    output logic                         sb_req,
    output logic [cache_pkg::addr_w-1:0] sb_addr,
    output logic [cache_pkg::data_w-1:0] sb_data,
    input  logic                         sb_gnt,
    input  logic                         mem_done
);
    import cache_pkg::*;

    localparam int ptr_w = (sb_depth > 1) ? $clog2(sb_depth) : 1;
    localparam int cnt_w = $clog2(sb_depth + 1);

    logic [addr_w-1:0] addr_q [sb_depth];
    logic [data_w-1:0] data_q [sb_depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              pop;

    // head leaves once its write completes
    assign pop = sb_gnt && mem_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(sb_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(sb_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= push_addr;
            data_q[wr_ptr] <= push_data;
        end
    end

    assign full    = (count == cnt_w'(sb_depth));
    assign sb_req  = (count != '0);
    assign sb_addr = addr_q[rd_ptr];
    assign sb_data = data_q[rd_ptr];

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req_valid,
    input  logic                           req_write,
    input  logic [cache_pkg::addr_w-1:0]   req_addr,
    input  logic [cache_pkg::data_w-1:0]   req_wdata,
    output logic                           resp_valid,
    output logic [cache_pkg::data_w-1:0]   resp_rdata,
    output logic                           busy,
    input  logic                           sb_full,
    output logic                           sb_push,
    input  logic [cache_pkg::num_ways-1:0] hit,
    input  logic [cache_pkg::num_ways-1:0] victim,
    output logic                           tag_we,
    output logic [cache_pkg::num_ways-1:0] way_sel,
    output logic                           fill,
    output logic [cache_pkg::num_ways-1:0] way_we,
    output logic [cache_pkg::data_w-1:0]   dwdata,
    input  logic [cache_pkg::data_w-1:0]   drdata,
    output logic                           rf_req,
    output logic [cache_pkg::addr_w-1:0]   rf_addr,
    input  logic                           rf_gnt,
    input  logic                           mem_done,
    input  logic [cache_pkg::data_w-1:0]   mem_rdata,
    output logic [cache_pkg::index_w-1:0]  index,
    output logic [cache_pkg::tag_w-1:0]    tag_in
);
    import cache_pkg::*;

    logic              state;
    logic [addr_w-1:0] miss_addr;
    logic              read_acc;
    logic              write_acc;
    logic              refill_done;
    logic [addr_w-1:0] look_addr;

    assign read_acc    = req_valid && !req_write && (state == st_idle);
    assign write_acc   = req_valid && req_write && (state == st_idle);
    assign refill_done = (state == st_refill) && rf_gnt && mem_done;

    // lookups use the held miss address while refilling
    assign look_addr = (state == st_refill) ? miss_addr : req_addr;
    assign index     = look_addr[index_w-1:0];
    assign tag_in    = look_addr[addr_w-1:index_w];

    assign rf_req  = (state == st_refill);
    assign rf_addr = miss_addr;
    assign busy    = (state == st_refill) || sb_full;
    assign sb_push = write_acc;

    // refill lands in the round-robin victim
    assign tag_we  = refill_done;
    assign way_sel = victim;
    assign fill    = refill_done;
    assign dwdata  = refill_done ? mem_rdata : req_wdata;

    always_comb begin
        if (refill_done) begin
            way_we = victim;
        end else if (write_acc) begin
            way_we = hit;
        end else begin
            way_we = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (write_acc || (read_acc && (|hit))) begin
                        resp_valid <= 1'b1;
                    end else if (read_acc) begin
                        state <= st_refill;
                    end
                end
                default: begin
                    if (refill_done) begin
                        state      <= st_idle;
                        resp_valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (read_acc && !(|hit)) begin
            miss_addr <= req_addr;
        end
        // hit data now, refill word straight from memory
        if (read_acc) begin
            resp_rdata <= drdata;
        end else if (refill_done) begin
            resp_rdata <= mem_rdata;
        end
    end

endmodule

// ==== verilog/data_store.sv ====
`timescale 1ns/100ps

module data_store (
    input  logic                           clk,
    input  logic [cache_pkg::index_w-1:0]  index,
    input  logic [cache_pkg::num_ways-1:0] way_we,
    input  logic [cache_pkg::data_w-1:0]   wdata,
    input  logic [cache_pkg::num_ways-1:0] rsel,
    output logic [cache_pkg::data_w-1:0]   rdata
);
    import cache_pkg::*;

    logic [data_w-1:0] words [num_ways][num_sets];

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (way_we[w]) begin
                words[w][index] <= wdata;
            end
        end
    end

    // one-hot select, zero when nothing hits
    always_comb begin
        rdata = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (rsel[w]) begin
                rdata = rdata | words[w][index];
            end
        end
    end

endmodule

// ==== verilog/line_state.sv ====
`timescale 1ns/100ps

module line_state (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cache_pkg::index_w-1:0]  index,
    input  logic                           fill,
    output logic [cache_pkg::num_ways-1:0] valid,
    output logic [cache_pkg::num_ways-1:0] victim
);
    import cache_pkg::*;

    logic [num_ways-1:0] valid_bits [num_sets];
    logic [way_w-1:0]    rr_ptr     [num_sets];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_bits[s] <= '0;
                rr_ptr[s]     <= '0;
            end
        end else if (fill) begin
            // filled way becomes valid, pointer moves on
            valid_bits[index] <= valid_bits[index] | victim;
            rr_ptr[index]     <= rr_ptr[index] + 1'b1;
        end
    end

    assign valid = valid_bits[index];

    // pointer to one-hot
    always_comb begin
        victim = '0;
        victim[rr_ptr[index]] = 1'b1;
    end

endmodule

// ==== verilog/tag_store.sv ====
`timescale 1ns/100ps

module tag_store (
    input  logic                           clk,
    input  logic [cache_pkg::index_w-1:0]  index,
    input  logic [cache_pkg::tag_w-1:0]    tag_in,
    input  logic [cache_pkg::num_ways-1:0] valid,
    input  logic                           tag_we,
    input  logic [cache_pkg::num_ways-1:0] way_sel,
    output logic [cache_pkg::num_ways-1:0] hit,
    output logic [cache_pkg::tag_w-1:0]    tag_out
);
    import cache_pkg::*;

    logic [tag_w-1:0] tag_rd [num_ways];

    genvar w;
    generate
        for (w = 0; w < num_ways; w = w + 1) begin : way_gen
            logic [tag_w-1:0] tags [num_sets];

            // only the selected way takes the new tag
            always_ff @(posedge clk) begin
                if (tag_we && way_sel[w]) begin
                    tags[index] <= tag_in;
                end
            end

            assign tag_rd[w] = tags[index];

            // stale tags in invalid ways never hit
            assign hit[w] = valid[w] && (tag_rd[w] == tag_in);
        end
    endgenerate

    // tag of the way picked by way_sel
    always_comb begin
        tag_out = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (way_sel[i]) begin
                tag_out = tag_out | tag_rd[i];
            end
        end
    end

endmodule

// ==== verilog/cache_pkg.sv ====
package cache_pkg;

    // word address split into tag and set index
    localparam int addr_w  = 10;
    localparam int index_w = 2;
    localparam int tag_w   = addr_w - index_w;
    localparam int num_sets = 1 << index_w;

    // one-hot way vectors are num_ways wide
    localparam int num_ways = 4;
    localparam int way_w    = $clog2(num_ways);

    localparam int data_w = 16;

    // backing memory
    localparam int mem_words   = 1 << addr_w;
    localparam int mem_latency = 3;

    // write queue in front of memory
    localparam int sb_depth = 2;

    // controller states
    localparam logic st_idle   = 1'b0;
    localparam logic st_refill = 1'b1;

endpackage
